//--- hw/riscv_defines.sv
// Shared definitions for the two-port RISC-V ALU cluster
// Word and register index widths, ALU opcodes, command kinds and port states
// Every RTL file and the testbench refer to these by scoped names

package riscv_defines;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	parameter int WORD_WIDTH   = 32;   // ALU sign logic relies on bit 31
	parameter int ADDR_WIDTH   = 5;    // Register index and shift amount
	parameter int ALU_OP_WIDTH = 4;

	////////////////////////////////////////
	// ALU opcodes
	////////////////////////////////////////

	typedef enum logic [ALU_OP_WIDTH-1:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SRL  = 4'd3,
		ALU_SRA  = 4'd4,
		ALU_SLT  = 4'd5,   // Signed compare
		ALU_SLTU = 4'd6,   // Unsigned compare
		ALU_AND  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_XOR  = 4'd9
	} alu_op_e;

	// Command kinds accepted by an execution port
	typedef enum logic {
		CMD_LOAD = 1'b0,   // rd <= imm
		CMD_ALU  = 1'b1    // rd <= rs1 op rs2
	} cmd_e;

	// Execution port FSM states
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,
		ST_BUS_REQ = 2'd1,
		ST_EXEC    = 2'd2,
		ST_ACK     = 2'd3
	} exec_state_e;

endpackage

//--- hw/alu.sv
// Purely combinational integer ALU of an execution port
// One adder covers add, sub and both compares
// One right shifter covers all shifts and left shifts go through bit reversal

`timescale 1ns/1ps

module alu (
	input  logic [riscv_defines::WORD_WIDTH-1:0] operand_a_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] operand_b_i,
	input  riscv_defines::alu_op_e               operator_i,
	output logic [riscv_defines::WORD_WIDTH-1:0] result_o
);

	localparam int W = riscv_defines::WORD_WIDTH;

	logic         negate_b;   // Two's complement of B for sub and compares
	logic [W-1:0] operand_b;

	always_comb begin
		case (operator_i)
			riscv_defines::ALU_SUB,
			riscv_defines::ALU_SLT,
			riscv_defines::ALU_SLTU: negate_b = 1'b1;
			default:                 negate_b = 1'b0;
		endcase
	end

	assign operand_b = negate_b ? (~operand_b_i + 1'b1) : operand_b_i;

	////////////////////////////////////////
	// Adder
	////////////////////////////////////////

	logic [W-1:0] adder_result;

	assign adder_result = operand_a_i + operand_b;

	////////////////////////////////////////
	// Shifter
	////////////////////////////////////////

	logic [riscv_defines::ADDR_WIDTH-1:0] shift_amount;
	logic                                 left_shift;
	logic                                 arith_shift;
	logic [W-1:0]                         operand_a_rev;
	logic [W-1:0]                         shift_operand;
	logic [W:0]                           shift_ext;      // Extra top bit carries the sign
	logic [W:0]                           shift_ext_res;
	logic [W-1:0]                         right_result;
	logic [W-1:0]                         left_result;
	logic [W-1:0]                         shift_result;

	assign shift_amount = operand_b_i[riscv_defines::ADDR_WIDTH-1:0];  // Low 5 bits only
	assign left_shift   = (operator_i == riscv_defines::ALU_SLL);
	assign arith_shift  = (operator_i == riscv_defines::ALU_SRA);

	// Reverse A so a right shift acts as a left shift
	always_comb begin
		for (int i = 0; i < W; i++) begin
			operand_a_rev[i] = operand_a_i[W-1-i];
		end
	end

	assign shift_operand = left_shift ? operand_a_rev : operand_a_i;
	assign shift_ext     = {arith_shift & shift_operand[W-1], shift_operand};
	assign shift_ext_res = $signed(shift_ext) >>> shift_amount;
	assign right_result  = shift_ext_res[W-1:0];

	// Undo the reversal for SLL
	always_comb begin
		for (int j = 0; j < W; j++) begin
			left_result[j] = right_result[W-1-j];
		end
	end

	assign shift_result = left_shift ? left_result : right_result;

	////////////////////////////////////////
	// Comparator
	////////////////////////////////////////

	logic signed_cmp;
	logic a_ge_b;
	logic [W-1:0] cmp_result;

	assign signed_cmp = (operator_i == riscv_defines::ALU_SLT);

	always_comb begin
		if (operand_a_i[W-1] == operand_b_i[W-1])
			a_ge_b = ~adder_result[W-1];           // Same signs so the difference decides
		else
			a_ge_b = operand_a_i[W-1] ^ signed_cmp; // Signs differ so the MSB of A decides
	end

	assign cmp_result = {{(W-1){1'b0}}, ~a_ge_b};

	////////////////////////////////////////
	// Result select
	////////////////////////////////////////

	always_comb begin
		case (operator_i)
			riscv_defines::ALU_ADD,
			riscv_defines::ALU_SUB:  result_o = adder_result;
			riscv_defines::ALU_SLL,
			riscv_defines::ALU_SRL,
			riscv_defines::ALU_SRA:  result_o = shift_result;
			riscv_defines::ALU_SLT,
			riscv_defines::ALU_SLTU: result_o = cmp_result;
			riscv_defines::ALU_AND:  result_o = operand_a_i & operand_b_i;
			riscv_defines::ALU_OR:   result_o = operand_a_i | operand_b_i;
			riscv_defines::ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
			default:                 result_o = adder_result;
		endcase
	end

endmodule

//--- hw/regfile.sv
// Shared 32 x 32 integer register file
// Two combinational read ports, one synchronous write port
// x0 reads as zero and ignores writes

`timescale 1ns/1ps

module regfile (
	input  logic                                 clk_i,
	input  logic                                 rst_n_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] raddr_a_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] raddr_b_i,
	output logic [riscv_defines::WORD_WIDTH-1:0] rdata_a_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] rdata_b_o,
	input  logic                                 we_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] waddr_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] wdata_i
);

	localparam int NUM_REGS = 2 ** riscv_defines::ADDR_WIDTH;

	logic [riscv_defines::WORD_WIDTH-1:0] regs_q [NUM_REGS];

	// Entry 0 clears on reset and is never written
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	// Reads see a write from the next cycle on
	assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
	assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

	// Write enable comes through the arbiter from a port FSM
	assert property (@(posedge clk_i) disable iff (!rst_n_i) !$isunknown(we_i))
		else $error("regfile write enable is unknown");

endmodule

//--- hw/regfile_arbiter.sv
// Round-robin arbiter for the register file bus of two execution ports
// Grant is registered and held while the owner keeps bus_req high
// On a tie the port that did not win last gets the bus

`timescale 1ns/1ps

module regfile_arbiter (
	input  logic                                 clk_i,
	input  logic                                 rst_n_i,
	// Port 0
	input  logic                                 bus_req_p0_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] raddr_a_p0_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] raddr_b_p0_i,
	input  logic                                 we_p0_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] waddr_p0_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] wdata_p0_i,
	output logic                                 bus_gnt_p0_o,
	// Port 1
	input  logic                                 bus_req_p1_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] raddr_a_p1_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] raddr_b_p1_i,
	input  logic                                 we_p1_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] waddr_p1_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] wdata_p1_i,
	output logic                                 bus_gnt_p1_o,
	// Read data back to both ports
	output logic [riscv_defines::WORD_WIDTH-1:0] rdata_a_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] rdata_b_o,
	// Register file side
	output logic [riscv_defines::ADDR_WIDTH-1:0] rf_raddr_a_o,
	output logic [riscv_defines::ADDR_WIDTH-1:0] rf_raddr_b_o,
	output logic                                 rf_we_o,
	output logic [riscv_defines::ADDR_WIDTH-1:0] rf_waddr_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] rf_wdata_o,
	input  logic [riscv_defines::WORD_WIDTH-1:0] rf_rdata_a_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] rf_rdata_b_i
);

	logic gnt0_q, gnt1_q, gnt0_d, gnt1_d;
	logic last_q, last_d;   // High when port 1 won last

	always_comb begin
		gnt0_d = 1'b0;
		gnt1_d = 1'b0;
		if (gnt0_q && bus_req_p0_i)
			gnt0_d = 1'b1;                  // Owner keeps the bus
		else if (gnt1_q && bus_req_p1_i)
			gnt1_d = 1'b1;
		else if (bus_req_p0_i && bus_req_p1_i) begin
			gnt0_d = last_q;                // Tie goes to the other port
			gnt1_d = ~last_q;
		end else begin
			gnt0_d = bus_req_p0_i;
			gnt1_d = bus_req_p1_i;
		end
		last_d = (gnt0_d || gnt1_d) ? gnt1_d : last_q;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gnt0_q <= 1'b0;
			gnt1_q <= 1'b0;
			last_q <= 1'b1;                 // Port 0 first after reset
		end else begin
			gnt0_q <= gnt0_d;
			gnt1_q <= gnt1_d;
			last_q <= last_d;
		end
	end

	assign bus_gnt_p0_o = gnt0_q;
	assign bus_gnt_p1_o = gnt1_q;

	// Bus mux where only the owner may write
	assign rf_raddr_a_o = gnt1_q ? raddr_a_p1_i : raddr_a_p0_i;
	assign rf_raddr_b_o = gnt1_q ? raddr_b_p1_i : raddr_b_p0_i;
	assign rf_waddr_o   = gnt1_q ? waddr_p1_i   : waddr_p0_i;
	assign rf_wdata_o   = gnt1_q ? wdata_p1_i   : wdata_p0_i;
	assign rf_we_o      = (gnt0_q & we_p0_i) | (gnt1_q & we_p1_i);
	assign rdata_a_o    = rf_rdata_a_i;
	assign rdata_b_o    = rf_rdata_b_i;

	assert property (@(posedge clk_i) disable iff (!rst_n_i) !(gnt0_q && gnt1_q))
		else $error("both ports granted the register file");

endmodule

//--- hw/exec_port.sv
// Host-facing execution port with its own ALU
// Takes one command per four-phase req/ack exchange
// Wins the register file bus, executes, writes rd, then acks with the result

`timescale 1ns/1ps

module exec_port (
	input  logic                                 clk_i,
	input  logic                                 rst_n_i,
	// Host channel
	input  logic                                 req_i,
	input  riscv_defines::cmd_e                  cmd_i,
	input  riscv_defines::alu_op_e               op_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] rs1_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] rs2_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] rd_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] imm_i,
	output logic                                 ack_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] result_o,
	// Register file bus
	output logic                                 bus_req_o,
	input  logic                                 bus_gnt_i,
	output logic [riscv_defines::ADDR_WIDTH-1:0] raddr_a_o,
	output logic [riscv_defines::ADDR_WIDTH-1:0] raddr_b_o,
	input  logic [riscv_defines::WORD_WIDTH-1:0] rdata_a_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] rdata_b_i,
	output logic                                 we_o,
	output logic [riscv_defines::ADDR_WIDTH-1:0] waddr_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] wdata_o
);

	riscv_defines::exec_state_e state_q, state_d;

	logic [riscv_defines::WORD_WIDTH-1:0] alu_result;
	logic [riscv_defines::WORD_WIDTH-1:0] wr_value;
	logic [riscv_defines::WORD_WIDTH-1:0] result_q;

	////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			riscv_defines::ST_IDLE:    if (req_i) state_d = riscv_defines::ST_BUS_REQ;
			riscv_defines::ST_BUS_REQ: if (bus_gnt_i) state_d = riscv_defines::ST_EXEC;
			riscv_defines::ST_EXEC:    state_d = riscv_defines::ST_ACK;  // Write on this edge
			riscv_defines::ST_ACK:     if (!req_i) state_d = riscv_defines::ST_IDLE;
			default:                   state_d = riscv_defines::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			state_q <= riscv_defines::ST_IDLE;
		else
			state_q <= state_d;
	end

	// Request held from BUS_REQ through the write
	assign bus_req_o = (state_q == riscv_defines::ST_BUS_REQ) ||
	                   (state_q == riscv_defines::ST_EXEC);
	assign ack_o     = (state_q == riscv_defines::ST_ACK);

	////////////////////////////////////////
	// Execute and write back
	////////////////////////////////////////

	alu u_alu (
		.operand_a_i (rdata_a_i),
		.operand_b_i (rdata_b_i),
		.operator_i  (op_i),
		.result_o    (alu_result)
	);

	assign wr_value  = (cmd_i == riscv_defines::CMD_LOAD) ? imm_i : alu_result;
	assign raddr_a_o = rs1_i;
	assign raddr_b_o = rs2_i;
	assign we_o      = (state_q == riscv_defines::ST_EXEC);   // x0 filtered in regfile
	assign waddr_o   = rd_i;
	assign wdata_o   = wr_value;

	// Returned word stays stable for the whole ACK phase
	always_ff @(posedge clk_i) begin
		if (state_q == riscv_defines::ST_EXEC)
			result_q <= wr_value;
	end

	assign result_o = result_q;

	// A write only happens in EXEC while this port owns the bus
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		we_o |-> (state_q == riscv_defines::ST_EXEC) && bus_gnt_i)
		else $error("port write outside EXEC or without grant");

endmodule

//--- hw/alu_cluster_top.sv
// Two-port ALU execution cluster
// Each port has its own ALU, the register file is shared
// Access to the register file goes through a round-robin arbiter

`timescale 1ns/1ps

module alu_cluster_top (
	input  logic                                 clk_i,
	input  logic                                 rst_n_i,
	// Port 0 channel
	input  logic                                 req_p0_i,
	input  riscv_defines::cmd_e                  cmd_p0_i,
	input  riscv_defines::alu_op_e               op_p0_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] rs1_p0_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] rs2_p0_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] rd_p0_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] imm_p0_i,
	output logic                                 ack_p0_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] result_p0_o,
	// Port 1 channel
	input  logic                                 req_p1_i,
	input  riscv_defines::cmd_e                  cmd_p1_i,
	input  riscv_defines::alu_op_e               op_p1_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] rs1_p1_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] rs2_p1_i,
	input  logic [riscv_defines::ADDR_WIDTH-1:0] rd_p1_i,
	input  logic [riscv_defines::WORD_WIDTH-1:0] imm_p1_i,
	output logic                                 ack_p1_o,
	output logic [riscv_defines::WORD_WIDTH-1:0] result_p1_o
);

	// Port side of the bus
	logic                                 bus_req_p0, bus_req_p1;
	logic                                 bus_gnt_p0, bus_gnt_p1;
	logic [riscv_defines::ADDR_WIDTH-1:0] raddr_a_p0, raddr_b_p0, waddr_p0;
	logic [riscv_defines::ADDR_WIDTH-1:0] raddr_a_p1, raddr_b_p1, waddr_p1;
	logic                                 we_p0, we_p1;
	logic [riscv_defines::WORD_WIDTH-1:0] wdata_p0, wdata_p1;
	logic [riscv_defines::WORD_WIDTH-1:0] rdata_a, rdata_b;       // Shared read data
	// Register file side
	logic [riscv_defines::ADDR_WIDTH-1:0] rf_raddr_a, rf_raddr_b, rf_waddr;
	logic                                 rf_we;
	logic [riscv_defines::WORD_WIDTH-1:0] rf_wdata, rf_rdata_a, rf_rdata_b;

	exec_port u_port0 (
		.clk_i, .rst_n_i,
		.req_i (req_p0_i), .cmd_i (cmd_p0_i), .op_i (op_p0_i),
		.rs1_i (rs1_p0_i), .rs2_i (rs2_p0_i), .rd_i (rd_p0_i), .imm_i (imm_p0_i),
		.ack_o (ack_p0_o), .result_o (result_p0_o),
		.bus_req_o (bus_req_p0), .bus_gnt_i (bus_gnt_p0),
		.raddr_a_o (raddr_a_p0), .raddr_b_o (raddr_b_p0),
		.rdata_a_i (rdata_a), .rdata_b_i (rdata_b),
		.we_o (we_p0), .waddr_o (waddr_p0), .wdata_o (wdata_p0)
	);

	exec_port u_port1 (
		.clk_i, .rst_n_i,
		.req_i (req_p1_i), .cmd_i (cmd_p1_i), .op_i (op_p1_i),
		.rs1_i (rs1_p1_i), .rs2_i (rs2_p1_i), .rd_i (rd_p1_i), .imm_i (imm_p1_i),
		.ack_o (ack_p1_o), .result_o (result_p1_o),
		.bus_req_o (bus_req_p1), .bus_gnt_i (bus_gnt_p1),
		.raddr_a_o (raddr_a_p1), .raddr_b_o (raddr_b_p1),
		.rdata_a_i (rdata_a), .rdata_b_i (rdata_b),
		.we_o (we_p1), .waddr_o (waddr_p1), .wdata_o (wdata_p1)
	);

	regfile_arbiter u_arbiter (
		.clk_i, .rst_n_i,
		.bus_req_p0_i (bus_req_p0), .raddr_a_p0_i (raddr_a_p0), .raddr_b_p0_i (raddr_b_p0),
		.we_p0_i (we_p0), .waddr_p0_i (waddr_p0), .wdata_p0_i (wdata_p0),
		.bus_gnt_p0_o (bus_gnt_p0),
		.bus_req_p1_i (bus_req_p1), .raddr_a_p1_i (raddr_a_p1), .raddr_b_p1_i (raddr_b_p1),
		.we_p1_i (we_p1), .waddr_p1_i (waddr_p1), .wdata_p1_i (wdata_p1),
		.bus_gnt_p1_o (bus_gnt_p1),
		.rdata_a_o (rdata_a), .rdata_b_o (rdata_b),
		.rf_raddr_a_o (rf_raddr_a), .rf_raddr_b_o (rf_raddr_b),
		.rf_we_o (rf_we), .rf_waddr_o (rf_waddr), .rf_wdata_o (rf_wdata),
		.rf_rdata_a_i (rf_rdata_a), .rf_rdata_b_i (rf_rdata_b)
	);

	regfile u_regfile (
		.clk_i, .rst_n_i,
		.raddr_a_i (rf_raddr_a), .raddr_b_i (rf_raddr_b),
		.rdata_a_o (rf_rdata_a), .rdata_b_o (rf_rdata_b),
		.we_i (rf_we), .waddr_i (rf_waddr), .wdata_i (rf_wdata)
	);

endmodule

//--- tb/alu_cluster_tb.sv
// Self-checking testbench for the two-port ALU cluster
// Drives both host channels with four-phase commands on the falling clock edge
// A shadow register file and a reference ALU give the expected result words
// A monitor compares every acknowledged result and a watchdog bounds the run

`timescale 1ns/1ps

module alu_cluster_tb;

	localparam int W   = riscv_defines::WORD_WIDTH;
	localparam int AW  = riscv_defines::ADDR_WIDTH;
	localparam int OPW = riscv_defines::ALU_OP_WIDTH;

	localparam int NUM_OPS        = 10;
	localparam int NUM_EDGES      = 5;
	localparam int RAND_PER_OP    = 8;
	localparam int CHAIN_LEN      = 16;
	localparam int CONT_ROUNDS    = 12;
	localparam int CYCLES_PER_CMD = 200;
	// Loads and readback, edge loads and ops, random ops, x0, chain, contention
	localparam int TOTAL_CMDS = 2 * 31 + NUM_EDGES + NUM_OPS * NUM_EDGES * NUM_EDGES +
	                            NUM_OPS * RAND_PER_OP * 3 + 2 + 1 + CHAIN_LEN + CONT_ROUNDS * 3;

	logic clk_i;
	logic rst_n_i;
	// Host channel 0
	logic                   req_p0, ack_p0;
	riscv_defines::cmd_e    cmd_p0;
	riscv_defines::alu_op_e op_p0;
	logic [AW-1:0]          rs1_p0, rs2_p0, rd_p0;
	logic [W-1:0]           imm_p0, result_p0;
	// Host channel 1
	logic                   req_p1, ack_p1;
	riscv_defines::cmd_e    cmd_p1;
	riscv_defines::alu_op_e op_p1;
	logic [AW-1:0]          rs1_p1, rs2_p1, rd_p1;
	logic [W-1:0]           imm_p1, result_p1;

	logic [W-1:0]           shadow [32];     // Model of the register file
	logic [W-1:0]           exp_word [2];    // Expected result per port
	riscv_defines::cmd_e    exp_cmd [2];
	riscv_defines::alu_op_e exp_op [2];
	string                  exp_name [2];
	int                     ack_order [$];   // Port numbers in order of ack rise
	logic [W-1:0]           edge_vals [NUM_EDGES] = '{32'h0, 32'hffff_ffff, 32'h8000_0000,
	                                                  32'h7fff_ffff, 32'd31};

	alu_cluster_top uut (
		.clk_i, .rst_n_i,
		.req_p0_i (req_p0), .cmd_p0_i (cmd_p0), .op_p0_i (op_p0),
		.rs1_p0_i (rs1_p0), .rs2_p0_i (rs2_p0), .rd_p0_i (rd_p0), .imm_p0_i (imm_p0),
		.ack_p0_o (ack_p0), .result_p0_o (result_p0),
		.req_p1_i (req_p1), .cmd_p1_i (cmd_p1), .op_p1_i (op_p1),
		.rs1_p1_i (rs1_p1), .rs2_p1_i (rs2_p1), .rd_p1_i (rd_p1), .imm_p1_i (imm_p1),
		.ack_p1_o (ack_p1), .result_p1_o (result_p1)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;   // 40 ns period
	end

	////////////////////////////////////////
	// Reference model and checks
	////////////////////////////////////////

	// RV32I semantics with the shift amount from the low 5 bits of B
	function automatic logic [W-1:0] alu_ref(input riscv_defines::alu_op_e op,
			input logic [W-1:0] a, input logic [W-1:0] b);
		case (op)
			riscv_defines::ALU_ADD:  return a + b;
			riscv_defines::ALU_SUB:  return a - b;
			riscv_defines::ALU_SLL:  return a << b[4:0];
			riscv_defines::ALU_SRL:  return a >> b[4:0];
			riscv_defines::ALU_SRA:  return W'($signed(a) >>> b[4:0]);
			riscv_defines::ALU_SLT:  return ($signed(a) < $signed(b)) ? W'(1) : W'(0);
			riscv_defines::ALU_SLTU: return (a < b) ? W'(1) : W'(0);
			riscv_defines::ALU_AND:  return a & b;
			riscv_defines::ALU_OR:   return a | b;
			riscv_defines::ALU_XOR:  return a ^ b;
			default:                 return '0;
		endcase
	endfunction

	task automatic stop_on_failure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_word(input string name, input logic [W-1:0] expected,
			input logic [W-1:0] actual);
		if (actual !== expected)
			stop_on_failure($sformatf("Error: test %s expected 0x%h actual 0x%h",
				name, expected, actual));
	endtask

	task automatic check_op_result(input riscv_defines::alu_op_e op, input string name,
			input logic [W-1:0] expected, input logic [W-1:0] actual);
		if (actual !== expected)
			stop_on_failure($sformatf("Error: test %s (%s) expected 0x%h actual 0x%h",
				name, op.name(), expected, actual));
	endtask

	function automatic logic port_ack(input int port);
		return (port == 0) ? ack_p0 : ack_p1;
	endfunction

	function automatic logic [W-1:0] port_result(input int port);
		return (port == 0) ? result_p0 : result_p1;
	endfunction

	// Result must be right and stay put for every cycle that ack is high
	always @(negedge clk_i) begin
		for (int p = 0; p < 2; p++) begin
			if (rst_n_i && port_ack(p)) begin
				if (exp_cmd[p] == riscv_defines::CMD_LOAD)
					check_word(exp_name[p], exp_word[p], port_result(p));
				else
					check_op_result(exp_op[p], exp_name[p], exp_word[p], port_result(p));
			end
		end
	end

	initial begin
		repeat (TOTAL_CMDS * CYCLES_PER_CMD + 10) @(posedge clk_i);
		stop_on_failure("Timeout, the DUT did not finish all commands in time");
	end

	////////////////////////////////////////
	// Host channel drivers
	////////////////////////////////////////

	task automatic drive_cmd(input int port, input riscv_defines::cmd_e cmd,
			input riscv_defines::alu_op_e op, input logic [AW-1:0] rs1,
			input logic [AW-1:0] rs2, input logic [AW-1:0] rd, input logic [W-1:0] imm,
			input string name, input int hold);
		logic [W-1:0] expected;
		@(negedge clk_i);
		expected = (cmd == riscv_defines::CMD_LOAD) ? imm : alu_ref(op, shadow[rs1], shadow[rs2]);
		exp_word[port] = expected;   // Set while ack is still low
		exp_cmd[port]  = cmd;
		exp_op[port]   = op;
		exp_name[port] = name;
		if (port == 0) begin
			cmd_p0 = cmd;
			op_p0  = op;
			rs1_p0 = rs1;
			rs2_p0 = rs2;
			rd_p0  = rd;
			imm_p0 = imm;
			req_p0 = 1'b1;
		end else begin
			cmd_p1 = cmd;
			op_p1  = op;
			rs1_p1 = rs1;
			rs2_p1 = rs2;
			rd_p1  = rd;
			imm_p1 = imm;
			req_p1 = 1'b1;
		end
		@(negedge clk_i);
		while (!port_ack(port)) @(negedge clk_i);
		ack_order.push_back(port);
		if (rd != '0)
			shadow[rd] = expected;   // x0 never changes
		for (int i = 0; i < hold; i++) begin
			@(negedge clk_i);
			if (!port_ack(port))
				stop_on_failure($sformatf("Port %0d dropped ack while req was held", port));
		end
		if (port == 0)
			req_p0 = 1'b0;
		else
			req_p1 = 1'b0;
		@(negedge clk_i);
		if (port_ack(port))
			stop_on_failure($sformatf("Port %0d kept ack one cycle after req fell", port));
	endtask

	task automatic load_reg(input int port, input logic [AW-1:0] rd, input logic [W-1:0] imm,
			input string name, input int hold);
		drive_cmd(port, riscv_defines::CMD_LOAD, riscv_defines::ALU_ADD, '0, '0, rd, imm,
			name, hold);
	endtask

	task automatic alu_cmd(input int port, input riscv_defines::alu_op_e op,
			input logic [AW-1:0] rs1, input logic [AW-1:0] rs2, input logic [AW-1:0] rd,
			input string name, input int hold);
		drive_cmd(port, riscv_defines::CMD_ALU, op, rs1, rs2, rd, '0, name, hold);
	endtask

	function automatic logic [AW-1:0] rand_reg(input int lo, input int hi);
		return AW'(lo + $urandom % (hi - lo + 1));
	endfunction

	function automatic riscv_defines::alu_op_e rand_op();
		return riscv_defines::alu_op_e'(OPW'($urandom % NUM_OPS));
	endfunction

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		int first;
		void'($urandom(86869));
		rst_n_i = 1'b0;
		req_p0 = 1'b0;
		req_p1 = 1'b0;
		cmd_p0 = riscv_defines::CMD_LOAD;
		cmd_p1 = riscv_defines::CMD_LOAD;
		op_p0  = riscv_defines::ALU_ADD;
		op_p1  = riscv_defines::ALU_ADD;
		{rs1_p0, rs2_p0, rd_p0, imm_p0} = '0;
		{rs1_p1, rs2_p1, rd_p1, imm_p1} = '0;
		for (int r = 0; r < 32; r++)
			shadow[r] = '0;   // Registers clear on reset
		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		@(negedge clk_i);
		if (ack_p0 || ack_p1)
			stop_on_failure("ack is high right after reset");
		// Loads with random holds, then readback through OR with x0
		for (int r = 1; r < 32; r++)
			load_reg(r % 2, AW'(r), $urandom, "load", $urandom % 4);
		for (int r = 1; r < 32; r++)
			alu_cmd(r % 2, riscv_defines::ALU_OR, AW'(r), '0, '0, "readback", 0);
		// Every opcode over all pairs of edge values
		for (int i = 0; i < NUM_EDGES; i++)
			load_reg(i % 2, AW'(i + 1), edge_vals[i], "edge_load", 0);
		for (int k = 0; k < NUM_OPS; k++)
			for (int i = 0; i < NUM_EDGES; i++)
				for (int j = 0; j < NUM_EDGES; j++)
					alu_cmd((i + j) % 2, riscv_defines::alu_op_e'(OPW'(k)), AW'(i + 1),
						AW'(j + 1), 10, "edge_op", 0);
		// Every opcode on random operands
		for (int k = 0; k < NUM_OPS; k++) begin
			for (int i = 0; i < RAND_PER_OP; i++) begin
				load_reg(0, 11, $urandom, "rand_load", 0);
				load_reg(1, 12, $urandom, "rand_load", 0);
				alu_cmd(i % 2, riscv_defines::alu_op_e'(OPW'(k)), 11, 12, 13, "rand_op", 0);
			end
		end
		// x0 returns the immediate but keeps reading zero
		load_reg(0, 0, 32'hdead_beef, "x0_load", 0);
		alu_cmd(1, riscv_defines::ALU_OR, 0, 0, 21, "x0_read", 0);
		// Write-back chain through x20
		load_reg(0, 20, $urandom, "chain_seed", 0);
		for (int k = 0; k < CHAIN_LEN; k++)
			alu_cmd(k % 2, rand_op(), 20, rand_reg(1, 31), 20, "writeback", $urandom % 4);
		// Each contention round is primed so the other port wins the tie
		for (int k = 0; k < CONT_ROUNDS; k++) begin
			alu_cmd(k % 2, riscv_defines::ALU_ADD, 1, 2, 22, "contention_prime", 0);
			fork
				alu_cmd(0, rand_op(), rand_reg(1, 7), rand_reg(1, 7), 24, "contention_p0", 0);
				alu_cmd(1, rand_op(), rand_reg(8, 15), rand_reg(8, 15), 25, "contention_p1", 0);
			join
			first = ack_order[ack_order.size() - 2];
			if (first != 1 - (k % 2))
				stop_on_failure($sformatf("Port %0d won a tie right after its own grant", first));
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- verilog.f
hw/riscv_defines.sv
hw/alu.sv
hw/regfile.sv
hw/regfile_arbiter.sv
hw/exec_port.sv
hw/alu_cluster_top.sv
tb/alu_cluster_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = alu_cluster_tb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
